// File: common/rsrvs_pkg.sv
// shared types for the two-operand reservation station
// typedefs are sized by the default widths below; rsrvs_top checks its own
// parameters against them, so a width change is made here first

package rsrvs_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // operand width in bits
  parameter int operand_width = 32;
  // order buffer tag, log2 of buffer depth
  parameter int extadr_width  = 3;
  // command set of the unit
  parameter int op_width      = 4;
  // extra command attributes
  parameter int opc_width     = 2;

  //////////////////////////////
  // vector types
  //////////////////////////////

  typedef logic [operand_width-1:0] operand_t;
  typedef logic [extadr_width-1:0]  extadr_t;
  typedef logic [op_width-1:0]      op_t;
  typedef logic [opc_width-1:0]     opc_t;

  //////////////////////////////
  // bundles
  //////////////////////////////

  // hazard of one operand, at most one of d1/d2 is set
  typedef struct packed {
    logic    d1;
    logic    d2;
    extadr_t tag;
  } hazard_t;

  // instruction as it leaves decode
  typedef struct packed {
    op_t      op;
    opc_t     opc;
    operand_t rfa;
    operand_t rfb;
    hazard_t  haz_a;
    hazard_t  haz_b;
  } dispatch_t;

  // write-back results, both ports share one tag
  typedef struct packed {
    extadr_t  tag;
    operand_t result1;
    operand_t result2;
  } wrbk_t;

  // command toward the execution unit
  typedef struct packed {
    logic     valid;
    op_t      op;
    opc_t     opc;
    operand_t rfa;
    operand_t rfb;
  } exec_cmd_t;

  // move of the busy slot in one cycle
  typedef enum logic [1:0] {
    STEP_HOLD  = 2'd0,
    STEP_LOAD  = 2'd1,
    STEP_ISSUE = 2'd2
  } rsrvs_step_e;

endpackage

// File: rsrvs/rsrvs_operand_slot.sv
// one operand of the busy slot with its hazard record
// write-back has no valid bit: the stored tag is compared every cycle while
// a hazard flag is set, so the write-back side must keep wrbk tag meaningful

module rsrvs_operand_slot #(
  parameter int operand_width = rsrvs_pkg::operand_width,
  parameter int extadr_width  = rsrvs_pkg::extadr_width
) (
  input  logic               cpu_clk,
  input  logic               rst_n_i,
  input  logic               flush_i,
  input  logic               padv_rsrvs_i,
  input  rsrvs_pkg::operand_t value_i,
  input  rsrvs_pkg::hazard_t  hazard_i,
  input  rsrvs_pkg::wrbk_t    wrbk_i,
  output rsrvs_pkg::operand_t value_o,
  output logic               resolved_o
);

  //////////////////////////////
  // hazard record
  //////////////////////////////

  // waiting on write-back port 1 / port 2
  logic                     d1_r;
  logic                     d2_r;
  // tag of the producing instruction
  logic [extadr_width-1:0]  tag_r;
  // operand as last seen
  logic [operand_width-1:0] value_r;
  // any flag raised
  logic                     waiting;
  // producer is writing back in this cycle
  logic                     tag_match;

  assign waiting   = d1_r | d2_r;
  assign tag_match = waiting & (tag_r == wrbk_i.tag);

  // flags, cleared by reset or flush like the rest of the control state
  always_ff @(posedge cpu_clk) begin
    if (!rst_n_i || flush_i) begin
      d1_r <= 1'b0;
      d2_r <= 1'b0;
    end else if (padv_rsrvs_i) begin
      d1_r <= hazard_i.d1;
      d2_r <= hazard_i.d2;
    end else if (tag_match) begin
      // resolved, value_r has taken the result on this edge
      d1_r <= 1'b0;
      d2_r <= 1'b0;
    end
  end

  // tag only matters while a flag is up
  always_ff @(posedge cpu_clk) begin
    if (padv_rsrvs_i) begin
      tag_r <= hazard_i.tag;
    end
  end

  //////////////////////////////
  // forwarding
  //////////////////////////////

  // while waiting the output follows the selected write-back port
  always_comb begin
    if (d1_r) begin
      value_o = wrbk_i.result1;
    end else if (d2_r) begin
      value_o = wrbk_i.result2;
    end else begin
      value_o = value_r;
    end
  end

  // register tracks the mux, so the matching result is kept on the edge
  always_ff @(posedge cpu_clk) begin
    if (padv_rsrvs_i) begin
      value_r <= value_i;
    end else begin
      value_r <= value_o;
    end
  end

  // operand usable in this cycle
  assign resolved_o = ~waiting | tag_match;

  // decode never reports one operand waiting on both ports
  a_single_port: assert property (
    @(posedge cpu_clk) disable iff (!rst_n_i)
    !(d1_r && d2_r)
  );

endmodule

// File: rsrvs/rsrvs_busy_stage.sv
// busy slot: holds one hazard-blocked instruction until its operands resolve
// the step comes from the execute stage; decode must not dispatch while the
// slot is occupied (unit_free_o low)

module rsrvs_busy_stage #(
  parameter int operand_width = rsrvs_pkg::operand_width,
  parameter int extadr_width  = rsrvs_pkg::extadr_width,
  parameter int op_width      = rsrvs_pkg::op_width,
  parameter int opc_width     = rsrvs_pkg::opc_width
) (
  input  logic                   cpu_clk,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  input  logic                   padv_rsrvs_i,
  input  rsrvs_pkg::rsrvs_step_e step_i,
  input  rsrvs_pkg::dispatch_t   dispatch_i,
  input  rsrvs_pkg::wrbk_t       wrbk_i,
  output rsrvs_pkg::exec_cmd_t   busy_cmd_o,
  output logic                   busy_free_o,
  output logic                   unit_free_o
);

  //////////////////////////////
  // command part
  //////////////////////////////

  // slot occupied
  logic                 busy_valid_r;
  logic [op_width-1:0]  busy_op_r;
  logic [opc_width-1:0] busy_opc_r;

  always_ff @(posedge cpu_clk) begin
    if (!rst_n_i || flush_i) begin
      busy_valid_r <= 1'b0;
    end else begin
      case (step_i)
        rsrvs_pkg::STEP_LOAD:  busy_valid_r <= 1'b1;
        rsrvs_pkg::STEP_ISSUE: busy_valid_r <= 1'b0;
        default:               busy_valid_r <= busy_valid_r;
      endcase
    end
  end

  // command and attributes follow the same steps
  always_ff @(posedge cpu_clk) begin
    case (step_i)
      rsrvs_pkg::STEP_LOAD: begin
        busy_op_r  <= dispatch_i.op;
        busy_opc_r <= dispatch_i.opc;
      end
      rsrvs_pkg::STEP_ISSUE: begin
        busy_op_r  <= '0;
        busy_opc_r <= '0;
      end
      default: begin
        busy_op_r  <= busy_op_r;
        busy_opc_r <= busy_opc_r;
      end
    endcase
  end

  //////////////////////////////
  // operands
  //////////////////////////////

  rsrvs_pkg::operand_t rfa;
  rsrvs_pkg::operand_t rfb;
  logic                resolved_a;
  logic                resolved_b;

  // operand A
  rsrvs_operand_slot #(
    .operand_width (operand_width),
    .extadr_width  (extadr_width)
  ) u_slot_a (
    .cpu_clk      (cpu_clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .padv_rsrvs_i (padv_rsrvs_i),
    .value_i      (dispatch_i.rfa),
    .hazard_i     (dispatch_i.haz_a),
    .wrbk_i       (wrbk_i),
    .value_o      (rfa),
    .resolved_o   (resolved_a)
  );

  // operand B
  rsrvs_operand_slot #(
    .operand_width (operand_width),
    .extadr_width  (extadr_width)
  ) u_slot_b (
    .cpu_clk      (cpu_clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .padv_rsrvs_i (padv_rsrvs_i),
    .value_i      (dispatch_i.rfb),
    .hazard_i     (dispatch_i.haz_b),
    .wrbk_i       (wrbk_i),
    .value_o      (rfb),
    .resolved_o   (resolved_b)
  );

  // forwarded view of the slot toward execute
  assign busy_cmd_o.valid = busy_valid_r;
  assign busy_cmd_o.op    = busy_op_r;
  assign busy_cmd_o.opc   = busy_opc_r;
  assign busy_cmd_o.rfa   = rfa;
  assign busy_cmd_o.rfb   = rfb;

  // no operand still waiting after this cycle's write-back
  assign busy_free_o = resolved_a & resolved_b;
  assign unit_free_o = ~busy_valid_r;

  // decode respects the unit-free flag
  a_dispatch_free: assert property (
    @(posedge cpu_clk) disable iff (!rst_n_i || flush_i)
    padv_rsrvs_i |-> unit_free_o
  );

endmodule

// File: rsrvs/rsrvs_exec_stage.sv
// execute latch and the per-cycle steering of the reservation station
// the latch holds while the unit has a command and taking_op_i is low

module rsrvs_exec_stage (
  input  logic                   cpu_clk,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  input  logic                   padv_rsrvs_i,
  input  logic                   taking_op_i,
  input  rsrvs_pkg::dispatch_t   dispatch_i,
  input  rsrvs_pkg::exec_cmd_t   busy_cmd_i,
  input  logic                   busy_free_i,
  output rsrvs_pkg::rsrvs_step_e step_o,
  output rsrvs_pkg::exec_cmd_t   exec_o
);

  //////////////////////////////
  // advance decision
  //////////////////////////////

  rsrvs_pkg::exec_cmd_t exec_r;
  // latch may take a new command
  logic                 exec_adv;
  // decode reports any operand waiting
  logic                 dispatch_hazard;
  // dispatch seen as an exec command
  rsrvs_pkg::exec_cmd_t dispatch_cmd;

  assign exec_adv = ~exec_r.valid | taking_op_i;

  assign dispatch_hazard = dispatch_i.haz_a.d1 | dispatch_i.haz_a.d2 |
                           dispatch_i.haz_b.d1 | dispatch_i.haz_b.d2;

  assign dispatch_cmd.valid = 1'b1;
  assign dispatch_cmd.op    = dispatch_i.op;
  assign dispatch_cmd.opc   = dispatch_i.opc;
  assign dispatch_cmd.rfa   = dispatch_i.rfa;
  assign dispatch_cmd.rfb   = dispatch_i.rfb;

  // step for the busy slot
  always_comb begin
    case ({exec_adv, padv_rsrvs_i})
      // latch stalled, new insn parks
      2'b01: step_o = rsrvs_pkg::STEP_LOAD;
      // no new insn, release busy if ready
      2'b10: begin
        if (busy_free_i) begin
          step_o = rsrvs_pkg::STEP_ISSUE;
        end else begin
          step_o = rsrvs_pkg::STEP_HOLD;
        end
      end
      // pipe advance, hazard parks the insn
      2'b11: begin
        if (dispatch_hazard) begin
          step_o = rsrvs_pkg::STEP_LOAD;
        end else begin
          step_o = rsrvs_pkg::STEP_HOLD;
        end
      end
      default: step_o = rsrvs_pkg::STEP_HOLD;
    endcase
  end

  //////////////////////////////
  // execute latch
  //////////////////////////////

  always_ff @(posedge cpu_clk) begin
    if (!rst_n_i || flush_i) begin
      exec_r <= '0;
    end else begin
      case ({exec_adv, padv_rsrvs_i})
        // unit still holds its command
        2'b00, 2'b01: exec_r <= exec_r;
        // busy contents with forwarded operands, or a bubble
        2'b10: begin
          if (busy_free_i) begin
            exec_r <= busy_cmd_i;
          end else begin
            exec_r <= '0;
          end
        end
        // straight from decode unless it went to busy
        2'b11: begin
          if (dispatch_hazard) begin
            exec_r <= '0;
          end else begin
            exec_r <= dispatch_cmd;
          end
        end
        default: exec_r <= exec_r;
      endcase
    end
  end

  assign exec_o = exec_r;

  // no command reaches the unit right after reset
  a_reset_empty: assert property (
    @(posedge cpu_clk)
    !rst_n_i |=> !exec_o.valid
  );

endmodule

// File: hdl/rsrvs_top.sv
// two-operand reservation station for one execution unit
// parameters must equal the package defaults, a mismatch stops elaboration

module rsrvs_top #(
  parameter int operand_width = rsrvs_pkg::operand_width,
  parameter int extadr_width  = rsrvs_pkg::extadr_width,
  parameter int op_width      = rsrvs_pkg::op_width,
  parameter int opc_width     = rsrvs_pkg::opc_width
) (
  input  logic                 cpu_clk,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  input  logic                 padv_rsrvs_i,
  input  logic                 taking_op_i,
  input  rsrvs_pkg::dispatch_t dispatch_i,
  input  rsrvs_pkg::wrbk_t     wrbk_i,
  output rsrvs_pkg::exec_cmd_t exec_o,
  output logic                 unit_free_o
);

  //////////////////////////////
  // width check
  //////////////////////////////

  // struct types are built from the package widths
  if ((operand_width != rsrvs_pkg::operand_width) ||
      (extadr_width  != rsrvs_pkg::extadr_width)  ||
      (op_width      != rsrvs_pkg::op_width)      ||
      (opc_width     != rsrvs_pkg::opc_width)) begin : g_width_mismatch
    $error("rsrvs_top: parameters differ from rsrvs_pkg widths");
  end

  //////////////////////////////
  // stages
  //////////////////////////////

  rsrvs_pkg::rsrvs_step_e step;
  rsrvs_pkg::exec_cmd_t   busy_cmd;
  logic                   busy_free;

  // busy slot, waits for write-back
  rsrvs_busy_stage #(
    .operand_width (operand_width),
    .extadr_width  (extadr_width),
    .op_width      (op_width),
    .opc_width     (opc_width)
  ) u_busy (
    .cpu_clk      (cpu_clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .padv_rsrvs_i (padv_rsrvs_i),
    .step_i       (step),
    .dispatch_i   (dispatch_i),
    .wrbk_i       (wrbk_i),
    .busy_cmd_o   (busy_cmd),
    .busy_free_o  (busy_free),
    .unit_free_o  (unit_free_o)
  );

  // execute latch, owns the step decision
  rsrvs_exec_stage u_exec (
    .cpu_clk      (cpu_clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .padv_rsrvs_i (padv_rsrvs_i),
    .taking_op_i  (taking_op_i),
    .dispatch_i   (dispatch_i),
    .busy_cmd_i   (busy_cmd),
    .busy_free_i  (busy_free),
    .step_o       (step),
    .exec_o       (exec_o)
  );

endmodule

// File: tests/tb_rsrvs_table.svh
// stimulus and expected values for tb_rsrvs, one row per test
// write-back tag 0 is the idle value, so hazard tags in the rows are 1..7
`ifndef TB_RSRVS_TABLE_SVH
`define TB_RSRVS_TABLE_SVH

// how a row is driven
localparam logic [1:0] kind_plain = 2'd0;
localparam logic [1:0] kind_stall = 2'd1;
localparam logic [1:0] kind_flush = 2'd2;

// field order here is the column order of the table below
typedef struct packed {
  logic [1:0]           kind;
  rsrvs_pkg::dispatch_t disp;
  // cycles after the dispatch edge until the producer writes back
  logic [3:0]           dly_a;
  logic [3:0]           dly_b;
  // value written back on the port named by the hazard
  rsrvs_pkg::operand_t  wb_a;
  rsrvs_pkg::operand_t  wb_b;
  // cycles taking_op stays low, stall rows only
  logic [3:0]           hold;
  rsrvs_pkg::operand_t  exp_rfa;
  rsrvs_pkg::operand_t  exp_rfb;
} row_t;

row_t rows[$];

task automatic fill_table();
  // columns: kind, op, opc, rfa, rfb, haz_a {d1,d2,tag}, haz_b {d1,d2,tag},
  //          dly_a, dly_b, wb_a, wb_b, hold, exp_rfa, exp_rfb
  // no hazard, straight to execute
  rows.push_back({kind_plain, 4'h3, 2'd1, 32'h1111_1111, 32'h2222_2222, 5'b00_000, 5'b00_000,
                  4'd0, 4'd0, 32'h0, 32'h0, 4'd0, 32'h1111_1111, 32'h2222_2222});
  // A waits on port 1
  rows.push_back({kind_plain, 4'h5, 2'd0, 32'hdead_0001, 32'h0000_00bb, 5'b10_011, 5'b00_000,
                  4'd2, 4'd0, 32'ha5a5_0001, 32'h0, 4'd0, 32'ha5a5_0001, 32'h0000_00bb});
  // B waits on port 2
  rows.push_back({kind_plain, 4'h6, 2'd2, 32'h0000_00aa, 32'hdead_0002, 5'b00_000, 5'b01_101,
                  4'd0, 4'd1, 32'h0, 32'h5a5a_0002, 4'd0, 32'h0000_00aa, 32'h5a5a_0002});
  // two tags, B resolves last
  rows.push_back({kind_plain, 4'h7, 2'd3, 32'hdead_0003, 32'hdead_0004, 5'b10_010, 5'b01_110,
                  4'd1, 4'd4, 32'h1234_5678, 32'h8765_4321, 4'd0, 32'h1234_5678, 32'h8765_4321});
  // two tags, A resolves last, ports swapped
  rows.push_back({kind_plain, 4'h8, 2'd1, 32'hdead_0005, 32'hdead_0006, 5'b01_100, 5'b10_111,
                  4'd3, 4'd2, 32'hcafe_0004, 32'hbeef_0004, 4'd0, 32'hcafe_0004, 32'hbeef_0004});
  // one tag feeds both ports in the same cycle
  rows.push_back({kind_plain, 4'h9, 2'd0, 32'hdead_0007, 32'hdead_0008, 5'b10_001, 5'b01_001,
                  4'd2, 4'd2, 32'h0f0f_0f0f, 32'hf0f0_f0f0, 4'd0, 32'h0f0f_0f0f, 32'hf0f0_f0f0});
  // unit stalls behind an earlier command
  rows.push_back({kind_stall, 4'ha, 2'd2, 32'h3333_3333, 32'h4444_4444, 5'b00_000, 5'b00_000,
                  4'd0, 4'd0, 32'h0, 32'h0, 4'd3, 32'h3333_3333, 32'h4444_4444});
  // flushed while parked, write-back still arrives
  rows.push_back({kind_flush, 4'hb, 2'd1, 32'hdead_0009, 32'h5555_5555, 5'b10_011, 5'b00_000,
                  4'd2, 4'd0, 32'h7777_7777, 32'h0, 4'd0, 32'h0, 32'h0});
  // normal traffic again after the flush
  rows.push_back({kind_plain, 4'hc, 2'd3, 32'h6666_6666, 32'hdead_000a, 5'b00_000, 5'b01_010,
                  4'd0, 4'd3, 32'h0, 32'h9999_9999, 4'd0, 32'h6666_6666, 32'h9999_9999});
endtask

`endif

// File: tests/tb_rsrvs.sv
// testbench for rsrvs_top with default widths
// inputs change 10 units after the rising edge
// outputs are sampled at that same point

module tb_rsrvs;

  logic                 cpu_clk;
  logic                 rst_n;
  logic                 flush;
  logic                 padv_rsrvs;
  logic                 taking_op;
  rsrvs_pkg::dispatch_t dispatch;
  rsrvs_pkg::wrbk_t     wrbk;
  rsrvs_pkg::exec_cmd_t exec_cmd;
  logic                 unit_free;

  integer seed;
  int     cycles;
  int     cycle_limit;
  int     cur_test;
  int     test_errs;
  int     n_pass;
  int     n_fail;

  `include "tb_rsrvs_table.svh"

  rsrvs_top uut (
    .cpu_clk      (cpu_clk),
    .rst_n_i      (rst_n),
    .flush_i      (flush),
    .padv_rsrvs_i (padv_rsrvs),
    .taking_op_i  (taking_op),
    .dispatch_i   (dispatch),
    .wrbk_i       (wrbk),
    .exec_o       (exec_cmd),
    .unit_free_o  (unit_free)
  );

  initial begin
    cpu_clk = 1'b0;
    forever #50 cpu_clk = ~cpu_clk;
  end

  // watchdog with its limit set once the table is loaded
  initial begin
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge cpu_clk);
      cycles++;
    end
    $display("timeout: run stopped after %0d cycles without finishing", cycles);
    $display("*** FAILED ***");
    $finish;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic next_cycle();
    @(posedge cpu_clk);
    #10;
  endtask

  task automatic fail_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("[FAIL] %0t test %0d: %s is %h, expected %h", $time, cur_test, what, got, exp);
    test_errs++;
  endtask

  task automatic fail_note(input string what);
    $display("%0t test %0d: %s", $time, cur_test, what);
    test_errs++;
  endtask

  // cycle of the last needed write-back or 0 when nothing waits
  function automatic int latest_match(input row_t row);
    int last;
    last = 0;
    if (row.disp.haz_a.d1 || row.disp.haz_a.d2)
      last = row.dly_a;
    if ((row.disp.haz_b.d1 || row.disp.haz_b.d2) && row.dly_b > last)
      last = row.dly_b;
    return last;
  endfunction

  // idle tag and random data except on the producer's cycle
  task automatic drive_wrbk(input row_t row, input int k);
    wrbk.tag     = '0;
    wrbk.result1 = $random(seed);
    wrbk.result2 = $random(seed);
    if ((row.disp.haz_a.d1 || row.disp.haz_a.d2) && k == row.dly_a) begin
      wrbk.tag = row.disp.haz_a.tag;
      if (row.disp.haz_a.d1)
        wrbk.result1 = row.wb_a;
      else
        wrbk.result2 = row.wb_a;
    end
    if ((row.disp.haz_b.d1 || row.disp.haz_b.d2) && k == row.dly_b) begin
      wrbk.tag = row.disp.haz_b.tag;
      if (row.disp.haz_b.d1)
        wrbk.result1 = row.wb_b;
      else
        wrbk.result2 = row.wb_b;
    end
  endtask

  // one-cycle dispatch from decode
  task automatic send_dispatch(input rsrvs_pkg::dispatch_t disp);
    if (!unit_free)
      fail_note("decode had to dispatch while the unit was not free");
    dispatch   = disp;
    padv_rsrvs = 1'b1;
    next_cycle();
    padv_rsrvs = 1'b0;
    dispatch   = '0;
  endtask

  task automatic check_cmd(input row_t row);
    if (exec_cmd.valid !== 1'b1)
      fail_note("execute latch is empty where a command was due");
    if (exec_cmd.op !== row.disp.op)
      fail_value("op", exec_cmd.op, row.disp.op);
    if (exec_cmd.opc !== row.disp.opc)
      fail_value("opc", exec_cmd.opc, row.disp.opc);
    if (exec_cmd.rfa !== row.exp_rfa)
      fail_value("rfa", exec_cmd.rfa, row.exp_rfa);
    if (exec_cmd.rfb !== row.exp_rfb)
      fail_value("rfb", exec_cmd.rfb, row.exp_rfb);
  endtask

  //////////////////////////////
  // test kinds
  //////////////////////////////

  task automatic run_plain(input row_t row);
    int k;
    int last;
    last = latest_match(row);
    drive_wrbk(row, 0);
    send_dispatch(row.disp);
    if (last > 0 && unit_free)
      fail_note("blocked command did not occupy the busy slot");
    k = 1;
    while (exec_cmd.valid !== 1'b1) begin
      drive_wrbk(row, k);
      next_cycle();
      k++;
    end
    // issue lands on the edge after the last match
    if (k <= last)
      fail_note("command issued before its last write-back");
    if (k > last + 1)
      fail_note("command issued later than the edge after its last write-back");
    check_cmd(row);
    drive_wrbk(row, 0);
    next_cycle();
  endtask

  task automatic run_stall(input row_t row);
    rsrvs_pkg::dispatch_t blocker;
    int h;
    blocker    = row.disp;
    blocker.op = ~row.disp.op;
    taking_op  = 1'b0;
    drive_wrbk(row, 0);
    send_dispatch(blocker);
    if (!exec_cmd.valid)
      fail_note("first command did not reach the execute latch");
    send_dispatch(row.disp);
    for (h = 0; h < row.hold; h++) begin
      if (unit_free)
        fail_note("unit stayed free behind a stalled execute latch");
      if (exec_cmd.op !== blocker.op)
        fail_value("stalled op", exec_cmd.op, blocker.op);
      next_cycle();
    end
    // unit takes the blocker and the parked command follows at once
    taking_op = 1'b1;
    next_cycle();
    check_cmd(row);
    next_cycle();
  endtask

  task automatic run_flush(input row_t row);
    int k;
    drive_wrbk(row, 0);
    send_dispatch(row.disp);
    if (unit_free)
      fail_note("blocked command did not occupy the busy slot");
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    if (!unit_free)
      fail_note("unit not free after flush");
    if (exec_cmd.valid)
      fail_note("execute latch still valid after flush");
    // producer still writes back
    for (k = 1; k <= row.dly_a + 2; k++) begin
      drive_wrbk(row, k);
      next_cycle();
      if (exec_cmd.valid)
        fail_note("flushed command reached the execute latch");
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int i;
    seed        = 89;
    rst_n       = 1'b0;
    flush       = 1'b0;
    padv_rsrvs  = 1'b0;
    taking_op   = 1'b1;
    dispatch    = '0;
    wrbk        = '0;
    n_pass      = 0;
    n_fail      = 0;
    cur_test    = 0;
    test_errs   = 0;
    cycle_limit = 0;
    fill_table();
    cycle_limit = rows.size() * 20;

    repeat (4) @(posedge cpu_clk);
    #10;
    rst_n = 1'b1;
    // reset leaves an empty latch and a free unit
    if (exec_cmd.valid !== 1'b0)
      fail_note("execute latch valid after reset");
    if (unit_free !== 1'b1)
      fail_note("unit not free after reset");
    $display("test 0 reset: %0d errors", test_errs);
    if (test_errs == 0)
      n_pass++;
    else
      n_fail++;

    for (i = 0; i < rows.size(); i++) begin
      cur_test  = i + 1;
      test_errs = 0;
      case (rows[i].kind)
        kind_stall: run_stall(rows[i]);
        kind_flush: run_flush(rows[i]);
        default:    run_plain(rows[i]);
      endcase
      $display("test %0d kind %0d: %0d errors", cur_test, rows[i].kind, test_errs);
      if (test_errs == 0)
        n_pass++;
      else
        n_fail++;
    end

    $display("tests %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+tests
common/rsrvs_pkg.sv
rsrvs/rsrvs_operand_slot.sv
rsrvs/rsrvs_busy_stage.sv
rsrvs/rsrvs_exec_stage.sv
hdl/rsrvs_top.sv
tests/tb_rsrvs.sv
